//--- build.f
+incdir+verilog
verilog/host_bus_pkg.sv
verilog/disp_types_pkg.sv
verilog/host_write_queue.sv
verilog/display_config_regs.sv
verilog/text_pixel_pipe.sv
verilog/text_video_top.sv
verification/text_video_checker.sv
verification/tb_text_video.sv

//--- run_sim.sh
#!/bin/sh
# compile and run the text video testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f build.f --top tb_text_video -Mdir obj_dir

./obj_dir/Vtb_text_video > sim.log 2>&1 || { cat sim.log; exit 1; }
cat sim.log

# the run counts as passed only if the log holds the pass line
grep -qF '*** TEST PASSED ***' sim.log
echo "simulation passed"

//--- verification/tb_text_video.sv
`timescale 1ns/10ps
`default_nettype none
`include "text_video_cfg.svh"

module tb_text_video
	import host_bus_pkg::*;
	import disp_types_pkg::*;
();

	localparam int DEPTH        = `TV_WQ_DEPTH;
	localparam int PIX_W        = `TV_PIX_W;
	localparam int WAIT_LIMIT   = 200;
	localparam int SCREEN_W     = `TV_ROW_WORDS * `TV_CELL_PIX;
	localparam int SCREEN_H     = (`TV_PAGE_WORDS / `TV_ROW_WORDS) * `TV_GLYPH_H;
	localparam int LOADED_LINES = 8 * `TV_GLYPH_H;        // eight text rows get random words
	localparam int LOAD_WORDS   = 8 * `TV_ROW_WORDS;

	logic       CLK;
	logic       reset;
	pix_coord_t pix;
	logic       host_wr_valid;
	host_wr_t   host_wr;
	logic       host_credit;
	logic       cfg_wr_valid;
	cfg_wr_t    cfg_wr;
	rgb_t       rgb;
	int         credits;
	int         seed_ret;
	int         checked;
	int         value_errors;
	int         protocol_errors;

	text_video_top i_dut (
		.CLK, .reset, .pix,
		.host_wr_valid, .host_wr, .host_credit,
		.cfg_wr_valid, .cfg_wr,
		.rgb
	);

	text_video_checker i_checker (
		.CLK, .reset, .pix,
		.host_wr_valid, .host_wr, .host_credit,
		.cfg_wr_valid, .cfg_wr,
		.rgb,
		.checked, .value_errors, .protocol_errors
	);

	initial begin
		CLK = 1'b0;
		forever #4 CLK = ~CLK;
	end

	function automatic pix_coord_t blank_pixel();
		pix_coord_t p;
		p.hpix = PIX_W'($urandom % 800);
		p.vpix = PIX_W'($urandom % 600);
		if ($urandom % 2)
			p.hpix = '0;
		else
			p.vpix = '0;
		return p;
	endfunction

	function automatic pix_coord_t random_pixel();
		pix_coord_t p;
		if ($urandom % 8 == 0)
			return blank_pixel();
		p.hpix = PIX_W'(1 + $urandom % SCREEN_W);
		if ($urandom % 4 == 0)
			p.vpix = PIX_W'(1 + $urandom % SCREEN_H); // mostly unwritten rows
		else
			p.vpix = PIX_W'(1 + $urandom % LOADED_LINES);
		return p;
	endfunction

	//////////////////////////////
	// host side, all driving on the falling edge
	task automatic next_cycle();
		@(negedge CLK);
		host_wr_valid = 1'b0;
		cfg_wr_valid  = 1'b0;
		if (host_credit)
			credits++;
	endtask

	task automatic print_summary();
		$display("checker: %0d pixels compared, %0d value errors, %0d protocol errors",
			checked, value_errors, protocol_errors);
	endtask

	task automatic wait_credits(input int need);
		int waited;
		waited = 0;
		while (credits < need) begin
			if (waited == WAIT_LIMIT) begin
				$display("timeout: host holds %0d credits, needs %0d", credits, need);
				print_summary();
				$display("*** TEST FAILED ***");
				$finish;
			end
			next_cycle();
			waited++;
		end
	endtask

	task automatic write_host(input logic [15:0] addr, input logic [15:0] data);
		next_cycle();
		wait_credits(1);
		host_wr_valid = 1'b1;
		host_wr.addr  = addr;
		host_wr.data  = data;
		credits--;
	endtask

	task automatic write_cfg(input cfg_reg_e idx, input logic [7:0] data);
		next_cycle();
		cfg_wr_valid = 1'b1;
		cfg_wr.idx   = idx;
		cfg_wr.data  = data;
	endtask

	task automatic scan(input int n);
		repeat (n) begin
			next_cycle();
			pix = random_pixel();
		end
	endtask

	task automatic flush();
		repeat (4) begin
			next_cycle();
			pix = blank_pixel();
		end
	endtask

	initial begin
		seed_ret      = $urandom(32'h0b5133d9);
		reset         = 1'b1;
		pix           = '0;
		host_wr_valid = 1'b0;
		host_wr       = '0;
		cfg_wr_valid  = 1'b0;
		cfg_wr        = '0;
		credits       = DEPTH;
		repeat (3) @(posedge CLK);
		@(negedge CLK);
		reset = 1'b0;

		scan(200); // empty memory, reset colours
		flush();

		// burst fills the queue while nothing can drain
		pix.hpix = PIX_W'(1 + $urandom % SCREEN_W);
		pix.vpix = PIX_W'(1 + $urandom % SCREEN_H);
		repeat (DEPTH) write_host({2'b01, 14'($urandom)}, 16'($urandom));
		repeat (8) next_cycle(); // credits stay withheld until pix blanks
		pix = blank_pixel();
		wait_credits(DEPTH);

		// glyph table and the top rows of both pages
		for (int g = 0; g < 2**`TV_GLYPH_AW; g++)
			write_host({2'b11, 6'($urandom), 8'(g)}, 16'($urandom));
		for (int i = 0; i < LOAD_WORDS; i++) begin
			write_host({2'b10, 1'($urandom), 13'(i)}, 16'($urandom));
			write_host({2'b10, 1'($urandom), 13'(`TV_PAGE_WORDS + i)}, 16'($urandom));
		end
		wait_credits(DEPTH);
		scan(3000);
		flush();

		// regions 00 and 01 aimed at loaded words
		repeat (40)
			write_host({1'b0, 1'($urandom), 1'b0, 13'($urandom % LOAD_WORDS)}, 16'($urandom));
		wait_credits(DEPTH);
		scan(500);
		flush();

		write_cfg(CFG_PAGE, 8'h01);
		write_cfg(CFG_FG, 8'($urandom));
		write_cfg(CFG_BG, 8'($urandom));
		flush();
		scan(3000);
		flush();
		write_cfg(CFG_PAGE, 8'h00);
		flush();
		scan(1000);
		flush();
		repeat (4) next_cycle(); // last predictions drain

		print_summary();
		if (value_errors + protocol_errors == 0 && checked > 0)
			$display("*** TEST PASSED ***");
		else
			$display("*** TEST FAILED ***");
		$finish;
	end

endmodule

`default_nettype wire

//--- verification/text_video_checker.sv
`timescale 1ns/10ps
`default_nettype none
`include "text_video_cfg.svh"

module text_video_checker
	import host_bus_pkg::*;
	import disp_types_pkg::*;
(
	input  wire        CLK,
	input  wire        reset,
	input  pix_coord_t pix,
	input  wire        host_wr_valid,
	input  host_wr_t   host_wr,
	input  wire        host_credit,
	input  wire        cfg_wr_valid,
	input  cfg_wr_t    cfg_wr,
	input  rgb_t       rgb,
	output int         checked,
	output int         value_errors,
	output int         protocol_errors
);

	logic [`TV_WORD_W-1:0] text_model  [2**`TV_TEXT_AW];
	logic [`TV_WORD_W-1:0] glyph_model [2**`TV_GLYPH_AW];
	logic       page_m;
	rgb_t       fg_m;
	rgb_t       bg_m;
	int         outstanding = 0;  // writes accepted but not yet credited
	int         next_out;
	int         n_checked = 0;
	int         n_value_err = 0;
	int         n_proto_err = 0;
	rgb_t       exp_q [3];        // predictions in flight, oldest at 2
	pix_coord_t pix_q [3];
	logic       chk_q [3] = '{1'b0, 1'b0, 1'b0};
	logic       blank_prev = 1'b1; // pix at the previous edge was blanking

	assign checked         = n_checked;
	assign value_errors    = n_value_err;
	assign protocol_errors = n_proto_err;

	initial begin
		for (int i = 0; i < 2**`TV_TEXT_AW; i++)
			text_model[i] = '0;
		for (int i = 0; i < 2**`TV_GLYPH_AW; i++)
			glyph_model[i] = '0;
	end

	function automatic rgb_t predict_rgb(pix_coord_t p);
		int x;
		int y;
		int waddr;
		int gaddr;
		int bit_pos;
		logic [`TV_WORD_W-1:0] tw;
		logic [5:0] code;
		if (p.hpix == 0 || p.vpix == 0)
			return 8'h00;
		x = int'(p.hpix) - 1;
		y = int'(p.vpix) - 1;
		waddr = (int'(page_m) * `TV_PAGE_WORDS + x / `TV_CELL_PIX
			+ (y / `TV_GLYPH_H) * `TV_ROW_WORDS) % (2**`TV_TEXT_AW);
		tw = text_model[waddr];
		case ((x % `TV_CELL_PIX) / `TV_GLYPH_PIX)
			0:       code = tw[17:12];
			1:       code = tw[11:6];
			default: code = tw[5:0];
		endcase
		gaddr   = (int'(code) * 4 + (y % 8) / 2) % (2**`TV_GLYPH_AW);
		bit_pos = 15 - ((x % 8) + (y % 2) * 8); // odd rows sit in the low byte
		return glyph_model[gaddr][bit_pos] ? fg_m : bg_m;
	endfunction

	//////////////////////////////
	// compare, then predict, then update the model
	always @(posedge CLK) begin
		if (chk_q[2]) begin
			n_checked++;
			if (rgb !== exp_q[2]) begin
				n_value_err++;
				$display("[ERROR] %0t: pix (%0d,%0d) gave rgb %02h, expected %02h",
					$time, pix_q[2].hpix, pix_q[2].vpix, rgb, exp_q[2]);
			end
		end
		exp_q[2] = exp_q[1];
		exp_q[1] = exp_q[0];
		pix_q[2] = pix_q[1];
		pix_q[1] = pix_q[0];
		chk_q[2] = chk_q[1];
		chk_q[1] = chk_q[0];
		pix_q[0] = pix;
		exp_q[0] = reset ? 8'h00 : predict_rgb(pix);
		chk_q[0] = reset || (outstanding == 0); // memory contents are settled

		if (reset) begin
			page_m      = 1'b0;
			fg_m        = `TV_FG_RESET;
			bg_m        = `TV_BG_RESET;
			outstanding = 0;
		end else begin
			next_out = outstanding + int'(host_wr_valid) - int'(host_credit);
			if (host_credit && outstanding == 0) begin
				n_proto_err++;
				$display("credit pulse at %0t with no write outstanding", $time);
				next_out = int'(host_wr_valid);
			end
			if (host_credit && !blank_prev) begin
				n_proto_err++;
				$display("credit pulse at %0t after a pop in a non-blanking cycle", $time);
			end
			if (next_out > `TV_WQ_DEPTH) begin
				n_proto_err++;
				$display("host issued a write at %0t without a free credit", $time);
			end
			outstanding = next_out;

			if (host_wr_valid) begin
				case (host_wr.addr[15:14])
					2'b10:   text_model[host_wr.addr[`TV_TEXT_AW-1:0]] = {2'b00, host_wr.data};
					2'b11:   glyph_model[host_wr.addr[`TV_GLYPH_AW-1:0]] = {2'b00, host_wr.data};
					default: ;  // dropped regions
				endcase
			end
			if (cfg_wr_valid) begin
				case (cfg_wr.idx)
					CFG_PAGE: page_m = cfg_wr.data[0];
					CFG_FG:   fg_m   = cfg_wr.data;
					CFG_BG:   bg_m   = cfg_wr.data;
					default:  ;
				endcase
			end
		end
		blank_prev = (pix.hpix == 0) || (pix.vpix == 0); // drain window of this edge
	end

endmodule

`default_nettype wire

//--- verilog/disp_types_pkg.sv
`default_nettype none
`include "text_video_cfg.svh"

package disp_types_pkg;

	typedef struct packed {
		logic [`TV_PIX_W-1:0] hpix;
		logic [`TV_PIX_W-1:0] vpix;
	} pix_coord_t;

	typedef logic [5:0] glyph_code_t;

	// slot 0 sits in the top bits
	typedef struct packed {
		glyph_code_t code0;
		glyph_code_t code1;
		glyph_code_t code2;
	} text_word_t;

	typedef logic [`TV_WORD_W-1:0]   glyph_word_t; // two 8-pixel rows in bits 15:0
	typedef logic [7:0]              rgb_t;
	typedef logic [`TV_TEXT_AW-1:0]  text_addr_t;
	typedef logic [`TV_GLYPH_AW-1:0] glyph_addr_t;

	typedef struct packed {
		logic page;
		rgb_t fg;
		rgb_t bg;
	} disp_cfg_t;

	typedef struct packed {
		logic                   is_glyph;
		text_addr_t             addr;  // glyph writes use the low bits only
		logic [`TV_WORD_W-1:0]  data;
	} mem_wr_t;

endpackage

`default_nettype wire

//--- verilog/display_config_regs.sv
`timescale 1ns/10ps
`default_nettype none
`include "text_video_cfg.svh"

module display_config_regs
	import host_bus_pkg::*;
	import disp_types_pkg::*;
(
	input  wire       CLK,
	input  wire       reset,
	input  wire       cfg_wr_valid,
	input  cfg_wr_t   cfg_wr,
	output disp_cfg_t disp_cfg
);

	disp_cfg_t cfg_q;

	// writes land on the next edge, no handshake
	always_ff @(posedge CLK) begin
		if (reset) begin
			cfg_q.page <= 1'b0;
			cfg_q.fg   <= `TV_FG_RESET;
			cfg_q.bg   <= `TV_BG_RESET;
		end else if (cfg_wr_valid) begin
			case (cfg_wr.idx)
				CFG_PAGE: cfg_q.page <= cfg_wr.data[0]; // page 1 starts at word 1620
				CFG_FG:   cfg_q.fg   <= cfg_wr.data;
				CFG_BG:   cfg_q.bg   <= cfg_wr.data;
				default:  ;
			endcase
		end
	end

	assign disp_cfg = cfg_q;

	a_cfg_idx_known: assert property (@(posedge CLK) disable iff (reset)
		cfg_wr_valid |-> (cfg_wr.idx inside {CFG_PAGE, CFG_FG, CFG_BG}))
		else $error("config write to unknown register %0d", cfg_wr.idx);

endmodule

`default_nettype wire

//--- verilog/host_bus_pkg.sv
`default_nettype none

package host_bus_pkg;

	// host write, region in addr[15:14]
	typedef struct packed {
		logic [15:0] addr;
		logic [15:0] data;
	} host_wr_t;

	typedef enum logic [1:0] {
		REGION_NONE,
		REGION_TEXT,   // addr[15:14] == 2'b10
		REGION_GLYPH   // addr[15:14] == 2'b11
	} mem_region_e;

	typedef enum logic [1:0] {
		CFG_PAGE,
		CFG_FG,
		CFG_BG
	} cfg_reg_e;

	typedef struct packed {
		cfg_reg_e   idx;
		logic [7:0] data;
	} cfg_wr_t;

endpackage

`default_nettype wire

//--- verilog/host_write_queue.sv
`timescale 1ns/10ps
`default_nettype none
`include "text_video_cfg.svh"

module host_write_queue
	import host_bus_pkg::*;
	import disp_types_pkg::*;
(
	input  wire      CLK,
	input  wire      reset,
	input  wire      host_wr_valid,
	input  host_wr_t host_wr,
	input  wire      blanking,
	output logic     mem_wr_valid,
	output mem_wr_t  mem_wr,
	output logic     host_credit
);

	localparam int DEPTH = `TV_WQ_DEPTH;
	localparam int PTR_W = $clog2(DEPTH);
	localparam int CNT_W = $clog2(DEPTH + 1);

	host_wr_t          fifo_mem [DEPTH];
	logic [PTR_W-1:0]  wr_ptr;
	logic [PTR_W-1:0]  rd_ptr;
	logic [CNT_W-1:0]  count;
	logic              pop;
	host_wr_t          head;
	mem_region_e       head_region;

	assign pop  = blanking && (count != '0); // one entry per blanking cycle
	assign head = fifo_mem[rd_ptr];

	//////////////////////////////
	// region decode at the head
	always_comb begin
		case (head.addr[15:14])
			2'b10:   head_region = REGION_TEXT;
			2'b11:   head_region = REGION_GLYPH;
			default: head_region = REGION_NONE;
		endcase
		mem_wr_valid    = pop && (head_region != REGION_NONE);
		mem_wr.is_glyph = (head_region == REGION_GLYPH);
		if (head_region == REGION_GLYPH)
			mem_wr.addr = {{(`TV_TEXT_AW - `TV_GLYPH_AW){1'b0}}, head.addr[`TV_GLYPH_AW-1:0]};
		else
			mem_wr.addr = head.addr[`TV_TEXT_AW-1:0];
		mem_wr.data = {{(`TV_WORD_W - 16){1'b0}}, head.data}; // zero-extended
	end

	always_ff @(posedge CLK) begin
		if (host_wr_valid)
			fifo_mem[wr_ptr] <= host_wr;
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			wr_ptr      <= '0;
			rd_ptr      <= '0;
			count       <= '0;
			host_credit <= 1'b0;
		end else begin
			if (host_wr_valid)
				wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
			if (pop)
				rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
			count       <= count + CNT_W'(host_wr_valid) - CNT_W'(pop);
			host_credit <= pop; // credit goes back the cycle after the pop
		end
	end

	// a host holding a credit can never find the queue full
	a_no_push_full: assert property (@(posedge CLK) disable iff (reset)
		host_wr_valid |-> (count != CNT_W'(DEPTH)))
		else $error("write pushed into a full queue");

	// the pointers must also show an entry behind every credit
	a_credit_needs_entry: assert property (@(posedge CLK) disable iff (reset)
		host_credit |-> $past((wr_ptr != rd_ptr) || (count == CNT_W'(DEPTH))))
		else $error("credit returned from an empty queue");

endmodule

`default_nettype wire

//--- verilog/text_pixel_pipe.sv
`timescale 1ns/10ps
`default_nettype none
`include "text_video_cfg.svh"

module text_pixel_pipe
	import disp_types_pkg::*;
(
	input  wire        CLK,
	input  wire        reset,
	input  pix_coord_t pix,
	input  disp_cfg_t  disp_cfg,
	input  wire        mem_wr_valid,
	input  mem_wr_t    mem_wr,
	output rgb_t       rgb
);

	text_word_t  text_mem  [2**`TV_TEXT_AW];
	glyph_word_t glyph_mem [2**`TV_GLYPH_AW];

	logic                 blank0;
	logic [`TV_PIX_W-1:0] x0;
	logic [`TV_PIX_W-1:0] y0;
	text_addr_t           page_base;
	text_addr_t           word_addr;
	logic [4:0]           cell_x;

	text_word_t  s1_text;
	logic [1:0]  s1_slot;
	logic [1:0]  s1_grow;
	logic [2:0]  s1_xbit;
	logic        s1_yodd;
	logic        s1_blank;

	glyph_code_t code;
	glyph_addr_t glyph_addr;

	glyph_word_t s2_glyph;
	logic [3:0]  s2_bit_idx;
	logic        s2_blank;
	logic        pix_bit;

	initial begin
		for (int i = 0; i < 2**`TV_TEXT_AW; i++)
			text_mem[i] = '0;
		for (int i = 0; i < 2**`TV_GLYPH_AW; i++)
			glyph_mem[i] = '0;
	end

	// host writes, only issued during blanking
	always_ff @(posedge CLK) begin
		if (mem_wr_valid && !mem_wr.is_glyph)
			text_mem[mem_wr.addr] <= text_word_t'(mem_wr.data);
		if (mem_wr_valid && mem_wr.is_glyph)
			glyph_mem[mem_wr.addr[`TV_GLYPH_AW-1:0]] <= mem_wr.data;
	end

	//////////////////////////////
	// stage 1: text word lookup
	always_comb begin
		blank0    = (pix.hpix == '0) || (pix.vpix == '0);
		x0        = pix.hpix - 1'b1;
		y0        = pix.vpix - 1'b1;
		page_base = disp_cfg.page ? text_addr_t'(`TV_PAGE_WORDS) : '0;
		word_addr = page_base + text_addr_t'(x0 / `TV_CELL_PIX)
			+ text_addr_t'(y0 / `TV_GLYPH_H) * text_addr_t'(`TV_ROW_WORDS);
		cell_x    = 5'(x0 % `TV_CELL_PIX); // position inside the word
	end

	//////////////////////////////
	// stage 2: glyph row lookup
	always_comb begin
		case (s1_slot)
			2'd0:    code = s1_text.code0;
			2'd1:    code = s1_text.code1;
			default: code = s1_text.code2;
		endcase
		glyph_addr = {code, s1_grow}; // code*4 + row pair
	end

	// stage 3 picks the pixel, msb first, odd rows in the low byte
	assign pix_bit = s2_glyph[4'd15 - s2_bit_idx];

	always_ff @(posedge CLK) begin
		s1_text    <= text_mem[word_addr];
		s1_slot    <= 2'(cell_x / `TV_GLYPH_PIX);
		s1_grow    <= 2'((y0 % `TV_GLYPH_H) / 2);
		s1_xbit    <= 3'(x0 % `TV_GLYPH_PIX);
		s1_yodd    <= y0[0];
		s2_glyph   <= glyph_mem[glyph_addr];
		s2_bit_idx <= {s1_yodd, s1_xbit};
	end

	always_ff @(posedge CLK) begin
		if (reset) begin
			s1_blank <= 1'b1; // pipe reads as blanking until flushed
			s2_blank <= 1'b1;
			rgb      <= '0;
		end else begin
			s1_blank <= blank0;
			s2_blank <= s1_blank;
			rgb      <= s2_blank ? '0 : (pix_bit ? disp_cfg.fg : disp_cfg.bg);
		end
	end

	// a blanking pixel comes out black exactly three edges later
	a_blank_black: assert property (@(posedge CLK) disable iff (reset)
		$past(blank0, 3) |-> (rgb == '0))
		else $error("non-zero rgb for a blanking pixel");

endmodule

`default_nettype wire

//--- verilog/text_video_cfg.svh
`ifndef TEXT_VIDEO_CFG_SVH
`define TEXT_VIDEO_CFG_SVH

// screen geometry, pixel numbers are 1-based with 0 for blanking
`define TV_PIX_W      10
`define TV_CELL_PIX   24    // one text word covers three glyphs
`define TV_GLYPH_PIX  8
`define TV_GLYPH_H    8
`define TV_ROW_WORDS  27
`define TV_PAGE_WORDS 1620  // 27 words x 60 text rows

// memory widths
`define TV_TEXT_AW    13
`define TV_GLYPH_AW   8
`define TV_WORD_W     18

// host write queue
`define TV_WQ_DEPTH   4

`define TV_FG_RESET   8'hff
`define TV_BG_RESET   8'hc0

`endif

//--- verilog/text_video_top.sv
`timescale 1ns/10ps
`default_nettype none

module text_video_top
	import host_bus_pkg::*;
	import disp_types_pkg::*;
(
	input  wire        CLK,
	input  wire        reset,
	input  pix_coord_t pix,
	input  wire        host_wr_valid,
	input  host_wr_t   host_wr,
	output logic       host_credit,
	input  wire        cfg_wr_valid,
	input  cfg_wr_t    cfg_wr,
	output rgb_t       rgb
);

	wire       blanking = (pix.hpix == '0) || (pix.vpix == '0); // queue drain window
	logic      mem_wr_valid;
	mem_wr_t   mem_wr;
	disp_cfg_t disp_cfg;

	host_write_queue i_queue (
		.CLK, .reset,
		.host_wr_valid, .host_wr,
		.blanking,
		.mem_wr_valid, .mem_wr,
		.host_credit
	);

	display_config_regs i_cfg (
		.CLK, .reset,
		.cfg_wr_valid, .cfg_wr,
		.disp_cfg
	);

	text_pixel_pipe i_pipe (
		.CLK, .reset,
		.pix, .disp_cfg,
		.mem_wr_valid, .mem_wr,
		.rgb
	);

endmodule

`default_nettype wire
